/* hw/seq_pkg.sv */
package seq_pkg;

    ////////////////////
    // Sizes
    localparam int N_THREADS   = 4;
    localparam int THREAD_W    = $clog2(N_THREADS);
    localparam int PC_W        = 11;
    localparam int LOCAL_W     = 7;
    localparam int BANK_W      = THREAD_W + LOCAL_W;
    localparam int ROM_LATENCY = 2;   // Cycles from pc to rom_word
    localparam int PROG_DEPTH  = 16;
    localparam int PROG_AW     = $clog2(PROG_DEPTH);

    localparam logic [PC_W-1:0] FIRST_PC = '0;

    ////////////////////
    // Word formats
    typedef enum logic [2:0] {
        OP_JMP     = 3'd0,
        OP_CALL    = 3'd1,
        OP_RET     = 3'd2,
        OP_WAITINV = 3'd3
    } op_t;

    typedef struct packed {
        logic       inve;
        logic [1:0] pos;
        logic [2:0] pom3;
        logic [2:0] pom2;
        logic [2:0] pom1;
        logic [2:0] cm;
        logic [1:0] pm;
        logic       me1;
        logic       me0;
    } csig_t;

    typedef struct packed {
        csig_t              csig;
        logic [LOCAL_W-1:0] waddr0;
        logic [LOCAL_W-1:0] raddr0;
        logic [LOCAL_W-1:0] raddr1;
    } data_view_t;

    // Same bit positions as data_view_t
    typedef struct packed {
        logic               spare_hi;   // inve slot
        logic [PC_W-1:0]    target;     // pos/pom3/pom2/pom1 slots
        op_t                op;         // cm slot
        logic [3:0]         spare_lo;   // pm, me1, me0 slots
        logic [LOCAL_W-1:0] ofs_dst;
        logic [LOCAL_W-1:0] ofs_src0;
        logic [LOCAL_W-1:0] ofs_src1;
    } ctrl_view_t;

    typedef union packed {
        data_view_t data;
        ctrl_view_t ctrl;
    } rom_body_t;

    typedef struct packed {
        logic      opc;    // Set for control words
        rom_body_t body;
    } rom_word_t;

    localparam csig_t NOP_CSIG = '0;

    ////////////////////
    // Microcode program
    function automatic rom_word_t data_word(input int cm, input int pm,
                                            input int w0, input int r0, input int r1);
        rom_word_t w;
        w = '0;
        w.body.data.csig.cm  = 3'(cm);
        w.body.data.csig.pm  = 2'(pm);
        w.body.data.csig.me0 = 1'b1;
        w.body.data.waddr0   = LOCAL_W'(w0);
        w.body.data.raddr0   = LOCAL_W'(r0);
        w.body.data.raddr1   = LOCAL_W'(r1);
        return w;
    endfunction

    function automatic rom_word_t ctrl_word(input op_t op, input int target,
                                            input int o_dst, input int o_src0,
                                            input int o_src1);
        rom_word_t w;
        w = '0;
        w.opc                = 1'b1;
        w.body.ctrl.op       = op;
        w.body.ctrl.target   = PC_W'(target);
        w.body.ctrl.ofs_dst  = LOCAL_W'(o_dst);
        w.body.ctrl.ofs_src0 = LOCAL_W'(o_src0);
        w.body.ctrl.ofs_src1 = LOCAL_W'(o_src1);
        return w;
    endfunction

    localparam rom_word_t JMP_FIRST = ctrl_word(OP_JMP, FIRST_PC, 0, 0, 0);

    localparam rom_word_t PROGRAM [PROG_DEPTH] = '{
        JMP_FIRST,                              // Idle loop
        data_word(1, 0, 10, 11, 12),
        data_word(2, 0, 13, 14, 15),
        ctrl_word(OP_CALL, 8, 5, 6, 7),
        data_word(3, 1, 20, 21, 22),
        ctrl_word(OP_WAITINV, 0, 0, 0, 0),
        data_word(4, 1, 30, 31, 32),
        JMP_FIRST,
        data_word(5, 2, 40, 41, 42),            // Subroutine entry
        data_word(6, 2, 125, 126, 127),         // Wraps once offsets are added
        ctrl_word(OP_RET, 0, 0, 0, 0),
        JMP_FIRST,
        JMP_FIRST,
        JMP_FIRST,
        JMP_FIRST,
        JMP_FIRST
    };

endpackage

/* hw/microcode_rom.sv */
`timescale 1ns/1ps

module microcode_rom
    import seq_pkg::*;
(
    input  logic            clk,
    input  logic [PC_W-1:0] pc,
    output rom_word_t       rom_word
);

    rom_word_t fetch;
    rom_word_t rd_word;   // First read stage

    // Table lookup on the low pc bits
    always_comb begin
        if (pc[PC_W-1:PROG_AW] != '0) begin
            fetch = JMP_FIRST;   // Outside the table
        end else begin
            fetch = PROGRAM[pc[PROG_AW-1:0]];
        end
    end

    // Two read stages like a block RAM with output register
    always_ff @(posedge clk) begin
        rd_word  <= fetch;
        rom_word <= rd_word;
    end

endmodule

/* hw/thread_ring.sv */
`timescale 1ns/1ps

module thread_ring
    import seq_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,
    input  logic                run,
    output logic                slot_last,
    output logic [THREAD_W-1:0] thread_id
);

    logic [N_THREADS-1:0] ring;   // One-hot slot

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ring <= '0;
        end else if (run) begin
            ring <= N_THREADS'(1);   // Restart at slot 0
        end else begin
            ring <= {ring[N_THREADS-2:0], ring[N_THREADS-1]};
        end
    end

    assign slot_last = ring[N_THREADS-1];

    // Slot to thread index
    // The offset covers the ROM latency plus the output register, so the
    // tag follows the word that is actually in flight
    always_comb begin
        thread_id = '0;
        for (int i = 0; i < N_THREADS; i++) begin
            if (ring[i]) begin
                thread_id = THREAD_W'((i + N_THREADS - (ROM_LATENCY + 1)) % N_THREADS);
            end
        end
    end

endmodule

/* hw/pc_control.sv */
`timescale 1ns/1ps

module pc_control
    import seq_pkg::*;
(
    input  logic            clk,
    input  logic            rstn,
    input  logic            run,
    input  logic            inv_rdy,
    input  logic            slot_last,
    input  rom_word_t       rom_word,
    output logic [PC_W-1:0] pc,
    output logic            busy
);

    logic [PC_W-1:0] ret_addr;
    logic [PC_W-1:0] pc_inc;
    logic            waitinv;    // Parked on WAITINV
    logic            inv_pend;   // inv_rdy came between ring turns
    logic            inv_go;
    logic            exec_ctrl;
    op_t             op;

    assign pc_inc = pc + PC_W'(1);
    assign op     = rom_word.body.ctrl.op;
    assign inv_go = inv_rdy | inv_pend;

    // Control word takes effect this turn
    assign exec_ctrl = slot_last & ~run & ~inv_go & rom_word.opc;

    assign busy = (pc != FIRST_PC) ^ run;

    ////////////////////
    // Program counter
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc <= FIRST_PC;
        end else if (run) begin
            pc <= PC_W'(1);
        end else if (slot_last) begin
            if (inv_go) begin
                pc <= pc_inc;   // Leave WAITINV
            end else if (rom_word.opc) begin
                case (op)
                    OP_JMP, OP_CALL: pc <= rom_word.body.ctrl.target;
                    OP_RET:          pc <= ret_addr;
                    default:         pc <= pc;   // WAITINV holds
                endcase
            end else if (!waitinv) begin
                pc <= pc_inc;
            end
        end
    end

    // One-level return address
    always_ff @(posedge clk) begin
        if (exec_ctrl && op == OP_CALL) begin
            ret_addr <= pc_inc;
        end
    end

    ////////////////////
    // Inverter wait
    always_ff @(posedge clk) begin
        if (!rstn) begin
            waitinv <= 1'b0;
        end else if (inv_rdy) begin
            waitinv <= 1'b0;
        end else if (exec_ctrl && op == OP_WAITINV) begin
            waitinv <= 1'b1;
        end
    end

    // Keeps a strobe that misses the last slot until the pc can move
    always_ff @(posedge clk) begin
        if (!rstn) begin
            inv_pend <= 1'b0;
        end else if (slot_last) begin
            inv_pend <= 1'b0;
        end else if (inv_rdy && waitinv) begin
            inv_pend <= 1'b1;
        end
    end

endmodule

/* hw/operand_addr_gen.sv */
`timescale 1ns/1ps

module operand_addr_gen
    import seq_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,
    input  logic                slot_last,
    input  logic [THREAD_W-1:0] thread_id,
    input  rom_word_t           rom_word,
    output csig_t               csig,
    output logic [BANK_W-1:0]   dst,
    output logic [BANK_W-1:0]   src0,
    output logic [BANK_W-1:0]   src1
);

    logic [LOCAL_W-1:0] ofs_dst;
    logic [LOCAL_W-1:0] ofs_src0;
    logic [LOCAL_W-1:0] ofs_src1;
    logic               call_hit;

    // Thread tag on top, offset local address below
    function automatic logic [BANK_W-1:0] bank_addr(
        input logic [THREAD_W-1:0] tid,
        input logic [LOCAL_W-1:0]  local_addr,
        input logic [LOCAL_W-1:0]  ofs
    );
        logic [LOCAL_W-1:0] sum;
        sum = local_addr + ofs;   // Stays inside the thread window
        return {tid, sum};
    endfunction

    assign call_hit = slot_last & rom_word.opc & (rom_word.body.ctrl.op == OP_CALL);

    ////////////////////
    // Call offsets
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ofs_dst  <= '0;
            ofs_src0 <= '0;
            ofs_src1 <= '0;
        end else if (call_hit) begin
            ofs_dst  <= rom_word.body.ctrl.ofs_dst;
            ofs_src0 <= rom_word.body.ctrl.ofs_src0;
            ofs_src1 <= rom_word.body.ctrl.ofs_src1;
        end
    end

    ////////////////////
    // Micro-op output
    always_ff @(posedge clk) begin
        if (!rstn) begin
            csig <= NOP_CSIG;
        end else begin
            csig <= rom_word.opc ? NOP_CSIG : rom_word.body.data.csig;
        end
    end

    always_ff @(posedge clk) begin
        dst  <= bank_addr(thread_id, rom_word.body.data.waddr0, ofs_dst);
        src0 <= bank_addr(thread_id, rom_word.body.data.raddr0, ofs_src0);
        src1 <= bank_addr(thread_id, rom_word.body.data.raddr1, ofs_src1);
    end

endmodule

/* hw/microcode_sequencer.sv */
`timescale 1ns/1ps

module microcode_sequencer
    import seq_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic              run,
    input  logic              inv_rdy,
    output logic              busy,
    output csig_t             csig,
    output logic [BANK_W-1:0] dst,
    output logic [BANK_W-1:0] src0,
    output logic [BANK_W-1:0] src1
);

    logic [PC_W-1:0]     pc;
    rom_word_t           rom_word;    // Two cycles behind pc
    logic                slot_last;
    logic [THREAD_W-1:0] thread_id;

    microcode_rom i_microcode_rom (
        .clk      (clk),
        .pc       (pc),
        .rom_word (rom_word)
    );

    thread_ring i_thread_ring (
        .clk       (clk),
        .rstn      (rstn),
        .run       (run),
        .slot_last (slot_last),
        .thread_id (thread_id)
    );

    // Sequencing, one step per ring turn
    pc_control i_pc_control (
        .clk       (clk),
        .rstn      (rstn),
        .run       (run),
        .inv_rdy   (inv_rdy),
        .slot_last (slot_last),
        .rom_word  (rom_word),
        .pc        (pc),
        .busy      (busy)
    );

    operand_addr_gen i_operand_addr_gen (
        .clk       (clk),
        .rstn      (rstn),
        .slot_last (slot_last),
        .thread_id (thread_id),
        .rom_word  (rom_word),
        .csig      (csig),
        .dst       (dst),
        .src0      (src0),
        .src1      (src1)
    );

endmodule

/* dv/tb_microcode_sequencer.sv */
`timescale 1ns/1ps

module tb_microcode_sequencer
    import seq_pkg::*;
();

    localparam int TIMEOUT_CYCLES =
        2 * (PROG_DEPTH * N_THREADS * (ROM_LATENCY + 1) + 60 + 20);

    typedef enum {PH_IDLE, PH_RUN, PH_DONE} phase_e;

    logic                clk;
    logic                rstn;
    logic                run;
    logic                inv_rdy;
    logic                busy;
    csig_t               csig;
    logic [BANK_W-1:0]   dst;
    logic [BANK_W-1:0]   src0;
    logic [BANK_W-1:0]   src1;
    logic [THREAD_W-1:0] dst_tid;
    logic [THREAD_W-1:0] src0_tid;
    logic [THREAD_W-1:0] src1_tid;

    // Expected data words in issue order
    csig_t              exp_csig_q [$];
    logic [LOCAL_W-1:0] exp_dst_q  [$];
    logic [LOCAL_W-1:0] exp_src0_q [$];
    logic [LOCAL_W-1:0] exp_src1_q [$];
    int                 n_exp    = 0;
    int                 wait_pos = -1;   // Data words before WAITINV

    phase_e               phase     = PH_IDLE;
    logic                 inv_seen  = 1'b0;
    csig_t                prev_csig = NOP_CSIG;
    logic [THREAD_W-1:0]  prev_tid  = '0;
    int                   seen      = 0;   // Data words observed so far
    int                   cur_pos   = 0;
    int                   run_len   = 0;
    logic                 run_end   = 1'b0;
    int                   end_len   = 0;
    logic [N_THREADS-1:0] tid_mask  = '0;
    logic [N_THREADS-1:0] end_mask  = '0;
    logic [THREAD_W-1:0]  exp_tid   = '0;
    csig_t                exp_csig  = NOP_CSIG;
    logic [LOCAL_W-1:0]   exp_dst   = '0;
    logic [LOCAL_W-1:0]   exp_src0  = '0;
    logic [LOCAL_W-1:0]   exp_src1  = '0;
    int                   cycle_cnt = 0;
    logic [31:0]          rng       = 32'h9a0a_32f9;

    assign dst_tid  = dst[BANK_W-1:LOCAL_W];
    assign src0_tid = src0[BANK_W-1:LOCAL_W];
    assign src1_tid = src1[BANK_W-1:LOCAL_W];

    microcode_sequencer i_microcode_sequencer (
        .clk     (clk),
        .rstn    (rstn),
        .run     (run),
        .inv_rdy (inv_rdy),
        .busy    (busy),
        .csig    (csig),
        .dst     (dst),
        .src0    (src0),
        .src1    (src1)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Helpers
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fail_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        $display("[ERROR] t=%0d ns %s: expected %0h, got %0h", $time, name, exp_v, act_v);
        fail_run();
    endtask

    task automatic event_error(input string what);
        $display("Error at t=%0d ns: %s", $time, what);
        fail_run();
    endtask

    // Walk the program with the sequencing rules, starting after run
    task automatic build_reference();
        rom_word_t w;
        int        pc;
        int        ret_pc;
        int        steps;
        int        o_dst;
        int        o_src0;
        int        o_src1;
        bit        done;
        pc = 1;
        ret_pc = 0;
        steps = 0;
        o_dst = 0;
        o_src0 = 0;
        o_src1 = 0;
        done = 1'b0;
        while (!done && steps < 4 * PROG_DEPTH) begin
            w = (pc < PROG_DEPTH) ? PROGRAM[PROG_AW'(pc)] : JMP_FIRST;
            steps++;
            if (!w.opc) begin
                exp_csig_q.push_back(w.body.data.csig);
                exp_dst_q.push_back(
                    LOCAL_W'((int'(w.body.data.waddr0) + o_dst) % (1 << LOCAL_W)));
                exp_src0_q.push_back(
                    LOCAL_W'((int'(w.body.data.raddr0) + o_src0) % (1 << LOCAL_W)));
                exp_src1_q.push_back(
                    LOCAL_W'((int'(w.body.data.raddr1) + o_src1) % (1 << LOCAL_W)));
                pc++;
            end else begin
                case (w.body.ctrl.op)
                    OP_JMP: begin
                        done = (w.body.ctrl.target == FIRST_PC);
                        pc   = int'(w.body.ctrl.target);
                    end
                    OP_CALL: begin
                        ret_pc = pc + 1;
                        o_dst  = int'(w.body.ctrl.ofs_dst);
                        o_src0 = int'(w.body.ctrl.ofs_src0);
                        o_src1 = int'(w.body.ctrl.ofs_src1);
                        pc     = int'(w.body.ctrl.target);
                    end
                    OP_RET:     pc = ret_pc;
                    OP_WAITINV: begin
                        wait_pos = exp_csig_q.size();
                        pc++;
                    end
                    default:    pc++;
                endcase
            end
        end
        n_exp = exp_csig_q.size();
    endtask

    task automatic apply_reset();
        rstn     = 1'b0;
        phase    = PH_IDLE;
        inv_seen = 1'b0;
        repeat (4) @(negedge clk);
        rstn = 1'b1;
    endtask

    task automatic wait_for_csig(input csig_t target);
        do @(negedge clk); while (csig != target);
    endtask

    ////////////////////
    // Output tracking
    // Outputs are stable at the falling edge
    always @(negedge clk) begin : track_outputs
        logic [THREAD_W-1:0] tid;
        tid     = dst_tid;
        run_end = 1'b0;
        if (!rstn) begin
            prev_csig = NOP_CSIG;
            run_len   = 0;
            seen      = 0;
            cur_pos   = 0;
        end else if (csig != prev_csig) begin
            if (prev_csig != NOP_CSIG) begin   // A run just ended
                run_end  = 1'b1;
                end_len  = run_len;
                end_mask = tid_mask;
            end
            if (csig != NOP_CSIG) begin
                cur_pos  = seen;
                seen++;
                run_len  = 1;
                tid_mask = N_THREADS'(1) << tid;
                exp_tid  = tid;   // Any start thread
            end else begin
                run_len = 0;
            end
        end else if (csig != NOP_CSIG) begin
            run_len++;
            exp_tid  = THREAD_W'((int'(prev_tid) + 1) % N_THREADS);
            tid_mask = tid_mask | (N_THREADS'(1) << tid);
        end
        prev_csig = csig;
        prev_tid  = tid;
        if (cur_pos < n_exp) begin
            exp_csig = exp_csig_q[cur_pos];
            exp_dst  = exp_dst_q[cur_pos];
            exp_src0 = exp_src0_q[cur_pos];
            exp_src1 = exp_src1_q[cur_pos];
        end
    end

    ////////////////////
    // Checks
    a_idle_busy : assert property (@(posedge clk) disable iff (!rstn) phase == PH_IDLE |-> !busy)
        else value_error("busy", 0, 32'($sampled(busy)));
    a_idle_nop : assert property (@(posedge clk) disable iff (!rstn)
        phase == PH_IDLE |-> csig == NOP_CSIG)
        else value_error("csig", 32'(NOP_CSIG), 32'($sampled(csig)));
    a_run_busy : assert property (@(posedge clk) disable iff (!rstn) run |=> busy)
        else value_error("busy", 1, 32'($sampled(busy)));
    a_op_busy : assert property (@(posedge clk) disable iff (!rstn) csig != NOP_CSIG |-> busy)
        else value_error("busy", 1, 32'($sampled(busy)));
    a_order : assert property (@(posedge clk) disable iff (!rstn)
        csig != NOP_CSIG |-> csig == exp_csig)
        else value_error("csig", 32'(exp_csig), 32'($sampled(csig)));
    a_count : assert property (@(posedge clk) disable iff (!rstn) seen <= n_exp)
        else value_error("data word count", n_exp, seen);
    a_run_len : assert property (@(posedge clk) disable iff (!rstn)
        run_end |-> end_len == N_THREADS)
        else value_error("run length", N_THREADS, end_len);
    a_threads : assert property (@(posedge clk) disable iff (!rstn) run_end |-> &end_mask)
        else value_error("thread coverage", 32'({N_THREADS{1'b1}}), 32'(end_mask));
    a_tid : assert property (@(posedge clk) disable iff (!rstn)
        csig != NOP_CSIG |-> {dst_tid, src0_tid, src1_tid} == {3{exp_tid}})
        else value_error("thread id dst/src0/src1", 32'({3{exp_tid}}),
                         32'($sampled({dst_tid, src0_tid, src1_tid})));
    a_dst : assert property (@(posedge clk) disable iff (!rstn)
        csig != NOP_CSIG |-> dst[LOCAL_W-1:0] == exp_dst)
        else value_error("dst", 32'(exp_dst), 32'($sampled(dst[LOCAL_W-1:0])));
    a_src0 : assert property (@(posedge clk) disable iff (!rstn)
        csig != NOP_CSIG |-> src0[LOCAL_W-1:0] == exp_src0)
        else value_error("src0", 32'(exp_src0), 32'($sampled(src0[LOCAL_W-1:0])));
    a_src1 : assert property (@(posedge clk) disable iff (!rstn)
        csig != NOP_CSIG |-> src1[LOCAL_W-1:0] == exp_src1)
        else value_error("src1", 32'(exp_src1), 32'($sampled(src1[LOCAL_W-1:0])));
    a_inv_wait : assert property (@(posedge clk) disable iff (!rstn)
        wait_pos >= 0 && csig != NOP_CSIG && cur_pos >= wait_pos |-> inv_seen)
        else event_error("data word after WAITINV was issued before inv_rdy");
    a_done_busy : assert property (@(posedge clk) disable iff (!rstn) phase == PH_DONE |-> !busy)
        else value_error("busy", 0, 32'($sampled(busy)));
    a_done_nop : assert property (@(posedge clk) disable iff (!rstn)
        phase == PH_DONE |-> csig == NOP_CSIG)
        else value_error("csig", 32'(NOP_CSIG), 32'($sampled(csig)));
    a_done_count : assert property (@(posedge clk) disable iff (!rstn)
        phase == PH_DONE |-> seen == n_exp)
        else value_error("data word count", n_exp, seen);

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    ////////////////////
    // Stimulus
    initial begin : stimulus
        int delay;
        rstn    = 1'b0;
        run     = 1'b0;
        inv_rdy = 1'b0;
        build_reference();
        repeat (2) begin
            apply_reset();
            repeat (2 * N_THREADS) @(negedge clk);
            run   = 1'b1;
            phase = PH_RUN;
            @(negedge clk);
            run = 1'b0;
            wait_for_csig(exp_csig_q[wait_pos - 1]);   // Last word before WAITINV
            wait_for_csig(NOP_CSIG);
            rng   = xorshift32(rng);
            delay = 20 + int'(rng % 41);
            repeat (delay) @(negedge clk);
            inv_rdy  = 1'b1;
            inv_seen = 1'b1;
            @(negedge clk);
            inv_rdy = 1'b0;
            wait_for_csig(exp_csig_q[n_exp - 1]);
            do @(negedge clk); while (busy);   // JMP 0 takes effect
            phase = PH_DONE;
            repeat (3 * N_THREADS) @(negedge clk);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* sim.f */
hw/seq_pkg.sv
hw/microcode_rom.sv
hw/thread_ring.sv
hw/pc_control.sv
hw/operand_addr_gen.sv
hw/microcode_sequencer.sv
dv/tb_microcode_sequencer.sv

/* Makefile */
TOP := tb_microcode_sequencer

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sim.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test completed successfully$$"

clean:
	rm -rf obj_dir
